//--- gpio_apb.f
src/gpio_pkg.sv
src/gpio_apb_regs.sv
src/gpio_input_sync.sv
src/gpio_edge_irq.sv
src/gpio_apb.sv
sim/tb_clock.sv
sim/gpio_apb_assert.sv
sim/gpio_apb_tb.sv

//--- sim/gpio_apb_assert.sv
////////////////////////////////////////////////////////////
// APB and interrupt assertions, bound to the GPIO top
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_apb_assert
(
    input logic                        HCLK,
    input logic                        HRESETn,
    input logic                        PSEL,
    input logic                        PENABLE,
    input logic                        PWRITE,
    input logic [gpio_pkg::DATA_W-1:0] PRDATA,
    input logic                        PSLVERR,
    input logic                        interrupt,
    input gpio_pkg::pad_vec_t          status
);

    int unsigned fail_count = 0;

    a_no_slverr: assert property (@(posedge HCLK) disable iff (!HRESETn) !PSLVERR)
    else
    begin
        fail_count++;
        $error("PSLVERR went high");
    end

    a_rdata_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !(PSEL && PENABLE && !PWRITE) |-> PRDATA == '0)
    else
    begin
        fail_count++;
        $error("PRDATA nonzero outside a read access");
    end

    // Status has to capture every interrupt pulse
    a_irq_status: assert property (@(posedge HCLK) disable iff (!HRESETn)
        interrupt |=> |status)
    else
    begin
        fail_count++;
        $error("interrupt pulse left no status bit");
    end

endmodule

bind gpio_apb gpio_apb_assert assert_i
(
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PWRITE    (PWRITE),
    .PRDATA    (PRDATA),
    .PSLVERR   (PSLVERR),
    .interrupt (interrupt),
    .status    (status)
);

//--- sim/gpio_apb_tb.sv
////////////////////////////////////////////////////////////
// GPIO APB testbench with random APB traffic and pad toggles
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_apb_tb;

    localparam int N_TRANS    = 11 + 45 + 20 + 16 + 8;  // APB transactions per test, summed
    localparam int MAX_CYCLES = N_TRANS * 40;

    logic HCLK, HRESETn, PWRITE, PSEL, PENABLE, PREADY, PSLVERR, interrupt;
    logic [gpio_pkg::ADDR_W-1:0] PADDR;
    logic [gpio_pkg::DATA_W-1:0] PWDATA, PRDATA;
    gpio_pkg::pad_vec_t gpio_in, gpio_in_sync, gpio_out, gpio_dir;

    // Reference model state
    gpio_pkg::pad_vec_t m_dir, m_out, m_inten, m_en, m_s1, m_s2, m_s3, m_status;
    gpio_pkg::inttype_e [gpio_pkg::PAD_NUM-1:0] m_type;

    logic [31:0] lfsr = 32'ha15a_6457;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_start_errs = 0;
    int cycles = 0;

    tb_clock clk_i (.HCLK(HCLK), .HRESETn(HRESETn));

    gpio_apb dut_i (.*);

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic gpio_pkg::pad_vec_t model_qual();
        gpio_pkg::pad_vec_t q;
        for (int k = 0; k < gpio_pkg::PAD_NUM; k++)
        begin
            case (m_type[k])
                gpio_pkg::INT_FALL: q[k] = ~m_s2[k] & m_s3[k];
                gpio_pkg::INT_RISE: q[k] = m_s2[k] & ~m_s3[k];
                gpio_pkg::INT_BOTH: q[k] = m_s2[k] ^ m_s3[k];
                default:            q[k] = 1'b0;
            endcase
        end
        return q & m_inten & m_en;
    endfunction

    function automatic gpio_pkg::apb_word_u model_read(input logic [4:0] off);
        gpio_pkg::apb_word_u w;
        w.raw = '0;
        case (off)
            gpio_pkg::ADDR_PADDIR:    w.raw = m_dir;
            gpio_pkg::ADDR_GPIOEN:    w.raw = m_en;
            gpio_pkg::ADDR_PADIN:     w.raw = m_s3;
            gpio_pkg::ADDR_PADOUT:    w.raw = m_out;
            gpio_pkg::ADDR_INTEN:     w.raw = m_inten;
            gpio_pkg::ADDR_INTSTATUS: w.raw = m_status;
            gpio_pkg::ADDR_INTTYPE_LO:
                for (int k = 0; k < 16; k++) w.raw[2*k +: 2] = m_type[k];
            gpio_pkg::ADDR_INTTYPE_HI:
                for (int k = 0; k < 16; k++) w.raw[2*k +: 2] = m_type[k+16];
            default:                  w.raw = '0;
        endcase
        return w;
    endfunction

    always @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            {m_dir, m_out, m_inten, m_en, m_s1, m_s2, m_s3, m_status} <= '0;
            m_type <= '0;
        end
        else
        begin
            if (PSEL && PENABLE && PWRITE)
            begin
                case (PADDR[6:2])
                    gpio_pkg::ADDR_PADDIR:    m_dir   <= PWDATA;
                    gpio_pkg::ADDR_GPIOEN:    m_en    <= PWDATA;
                    gpio_pkg::ADDR_PADOUT:    m_out   <= PWDATA;
                    gpio_pkg::ADDR_PADOUTSET: m_out   <= m_out | PWDATA;
                    gpio_pkg::ADDR_PADOUTCLR: m_out   <= m_out & ~PWDATA;
                    gpio_pkg::ADDR_INTEN:     m_inten <= PWDATA;
                    gpio_pkg::ADDR_INTTYPE_LO:
                        for (int k = 0; k < 16; k++)
                            m_type[k] <= gpio_pkg::inttype_e'(PWDATA[2*k +: 2]);
                    gpio_pkg::ADDR_INTTYPE_HI:
                        for (int k = 0; k < 16; k++)
                            m_type[k+16] <= gpio_pkg::inttype_e'(PWDATA[2*k +: 2]);
                    default: ;
                endcase
            end
            m_s1 <= (gpio_in & m_en) | (m_s1 & ~m_en);
            m_s2 <= (m_s1 & m_en) | (m_s2 & ~m_en);
            m_s3 <= (m_s2 & m_en) | (m_s3 & ~m_en);
            if (model_qual() != '0)
                m_status <= m_status | model_qual();  // Set beats clear
            else if (PSEL && PENABLE && !PWRITE && PADDR[6:2] == gpio_pkg::ADDR_INTSTATUS)
                m_status <= '0;
        end
    end

    always @(posedge HCLK)
    begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: the run took more than %0d clock cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic check_word(input gpio_pkg::apb_word_u got, exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got.raw, exp.raw);
        end
    endtask

    task automatic check_pads(input gpio_pkg::pad_vec_t got, exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic apb_write(input logic [4:0] off, input logic [31:0] data);
        PADDR  = {5'b0, off, 2'b00};
        PWDATA = data;
        PWRITE = 1'b1;
        PSEL   = 1'b1;
        @(posedge HCLK);
        #1 PENABLE = 1'b1;
        #2 check_bit(PREADY, 1'b1, "PREADY in write access");
        @(posedge HCLK);
        #1 PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    // Samples both the bus and the model inside the access cycle
    task automatic apb_read(input logic [4:0] off, output gpio_pkg::apb_word_u got, exp);
        PADDR  = {5'b0, off, 2'b00};
        PWRITE = 1'b0;
        PSEL   = 1'b1;
        @(posedge HCLK);
        #1 PENABLE = 1'b1;
        #2 got.raw = PRDATA;
        exp = model_read(off);
        check_bit(PREADY, 1'b1, "PREADY in read access");
        @(posedge HCLK);
        #1 PSEL = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic read_check(input logic [4:0] off, input string msg);
        gpio_pkg::apb_word_u got;
        gpio_pkg::apb_word_u exp;
        apb_read(off, got, exp);
        check_word(got, exp, $sformatf("%s offset %0d", msg, off));
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start_errs);
        tests++;
        test_start_errs = errors;
    endtask

    initial
    begin
        logic [4:0] off;
        logic [4:0] pad;
        logic hit;
        gpio_pkg::apb_word_u got;
        gpio_pkg::apb_word_u exp;
        logic [4:0] map[6];
        map = '{gpio_pkg::ADDR_PADDIR, gpio_pkg::ADDR_PADOUT, gpio_pkg::ADDR_INTEN,
                gpio_pkg::ADDR_GPIOEN, gpio_pkg::ADDR_INTTYPE_LO, gpio_pkg::ADDR_INTTYPE_HI};
        PADDR = '0;
        PWDATA = '0;
        PWRITE = 1'b0;
        PSEL = 1'b0;
        PENABLE = 1'b0;
        gpio_in = '0;
        @(posedge HRESETn);
        @(posedge HCLK);
        #1;

        for (int a = 0; a < 11; a++)
            read_check(5'(a), "reset value");
        check_pads(gpio_out, '0, "gpio_out after reset");
        check_pads(gpio_dir, '0, "gpio_dir after reset");
        check_bit(interrupt, 1'b0, "interrupt after reset");
        finish_test("reset");

        for (int i = 0; i < 20; i++)
        begin
            off = map[rand_bits(3) % 6];
            apb_write(off, rand_bits(32));
            read_check(off, "readback");
        end
        read_check(gpio_pkg::ADDR_PADOUTSET, "write-only");
        read_check(gpio_pkg::ADDR_PADOUTCLR, "write-only");
        read_check(5'd10, "unmapped");
        read_check(5'd17, "unmapped");
        read_check(5'd31, "unmapped");
        check_pads(gpio_out, m_out, "gpio_out");
        check_pads(gpio_dir, m_dir, "gpio_dir");
        finish_test("register readback");

        for (int i = 0; i < 10; i++)
        begin
            off = rand_bits(1) ? gpio_pkg::ADDR_PADOUTSET : gpio_pkg::ADDR_PADOUTCLR;
            apb_write(off, rand_bits(32));
            check_pads(gpio_out, m_out, "gpio_out after set/clear");
            read_check(gpio_pkg::ADDR_PADOUT, "OUT after set/clear");
        end
        finish_test("set and clear");

        for (int i = 0; i < 8; i++)
        begin
            apb_write(gpio_pkg::ADDR_GPIOEN, rand_bits(32));
            gpio_in = rand_bits(32);
            repeat (4) @(posedge HCLK);
            #1;
            check_pads(gpio_in_sync, m_s2, "gpio_in_sync");
            check_pads(gpio_in_sync & m_en, gpio_in & m_en, "enabled pads sync");
            apb_read(gpio_pkg::ADDR_PADIN, got, exp);
            check_word(got, exp, "PADIN");
            check_pads(got.raw & m_en, gpio_in & m_en, "enabled pads PADIN");
        end
        finish_test("input sync");

        apb_write(gpio_pkg::ADDR_INTEN, '0);
        apb_write(gpio_pkg::ADDR_GPIOEN, '1);
        repeat (4) @(posedge HCLK);  // Let stale stages catch up
        #1;
        apb_write(gpio_pkg::ADDR_INTTYPE_LO, rand_bits(32));
        apb_write(gpio_pkg::ADDR_INTTYPE_HI, rand_bits(32));
        apb_write(gpio_pkg::ADDR_INTEN, rand_bits(32));
        read_check(gpio_pkg::ADDR_INTSTATUS, "status before toggles");
        for (int i = 0; i < 16; i++)
        begin
            pad = 5'(rand_bits(5));
            gpio_in[pad] = ~gpio_in[pad];
            hit = m_inten[pad] && (m_type[pad] == gpio_pkg::INT_BOTH
                || (m_type[pad] == gpio_pkg::INT_RISE && gpio_in[pad])
                || (m_type[pad] == gpio_pkg::INT_FALL && !gpio_in[pad]));
            for (int c = 0; c < 5; c++)
            begin
                @(posedge HCLK);
                #1 check_bit(interrupt, c == 1 && hit, $sformatf("interrupt pad %0d", pad));
            end
        end
        read_check(gpio_pkg::ADDR_INTSTATUS, "status after toggles");
        apb_read(gpio_pkg::ADDR_INTSTATUS, got, exp);
        check_word(got, '0, "status after clearing read");
        finish_test("edge interrupts");

        errors = errors + dut_i.assert_i.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
////////////////////////////////////////////////////////////
// Testbench clock (20 ns) and 5-cycle reset generator
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_clock
(
    output logic HCLK,
    output logic HRESETn
);

    initial
    begin
        HCLK    = 1'b0;
        HRESETn = 1'b0;
        repeat (5) @(posedge HCLK);
        #1 HRESETn = 1'b1;
    end

    always #10 HCLK = ~HCLK;

endmodule

//--- src/gpio_apb.sv
////////////////////////////////////////////////////////////
// APB GPIO top, one bank of 32 pads with edge interrupts
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_apb
(
    input  logic                        HCLK,
    input  logic                        HRESETn,

    input  logic [gpio_pkg::ADDR_W-1:0] PADDR,
    input  logic [gpio_pkg::DATA_W-1:0] PWDATA,
    input  logic                        PWRITE,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    output logic [gpio_pkg::DATA_W-1:0] PRDATA,
    output logic                        PREADY,
    output logic                        PSLVERR,

    input  gpio_pkg::pad_vec_t          gpio_in,
    output gpio_pkg::pad_vec_t          gpio_in_sync,
    output gpio_pkg::pad_vec_t          gpio_out,
    output gpio_pkg::pad_vec_t          gpio_dir,
    output logic                        interrupt
);

    gpio_pkg::gpio_cfg_t cfg;
    gpio_pkg::pad_edge_t edges;
    gpio_pkg::pad_vec_t  pad_in;
    gpio_pkg::pad_vec_t  status;
    logic                status_clr;

    gpio_apb_regs regs_i
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PWRITE     (PWRITE),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PRDATA     (PRDATA),
        .pad_in     (pad_in),
        .status     (status),
        .cfg        (cfg),
        .status_clr (status_clr)
    );

    gpio_input_sync sync_i
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .gpio_in  (gpio_in),
        .cfg      (cfg),
        .sync_out (gpio_in_sync),
        .pad_in   (pad_in),
        .edges    (edges)
    );

    gpio_edge_irq irq_i
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .cfg        (cfg),
        .edges      (edges),
        .status_clr (status_clr),
        .status     (status),
        .interrupt  (interrupt)
    );

    assign gpio_out = cfg.out;
    assign gpio_dir = cfg.dir;

    assign PREADY  = 1'b1;  // No wait states
    assign PSLVERR = 1'b0;

endmodule

//--- src/gpio_apb_regs.sv
////////////////////////////////////////////////////////////
// GPIO register block with APB decode, config registers
// and the read data mux
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_apb_regs
(
    input  logic                        HCLK,
    input  logic                        HRESETn,

    input  logic [gpio_pkg::ADDR_W-1:0] PADDR,
    input  logic [gpio_pkg::DATA_W-1:0] PWDATA,
    input  logic                        PWRITE,
    input  logic                        PSEL,
    input  logic                        PENABLE,
    output logic [gpio_pkg::DATA_W-1:0] PRDATA,

    input  gpio_pkg::pad_vec_t          pad_in,
    input  gpio_pkg::pad_vec_t          status,
    output gpio_pkg::gpio_cfg_t         cfg,
    output logic                        status_clr
);

    localparam int HALF = gpio_pkg::PAD_NUM / 2;

    logic [4:0]          offset;
    logic                wr_acc;
    logic                rd_acc;
    gpio_pkg::apb_word_u wdata;
    gpio_pkg::apb_word_u rdata;

    assign offset = PADDR[6:2];
    assign wr_acc = PSEL & PENABLE & PWRITE;
    assign rd_acc = PSEL & PENABLE & ~PWRITE;

    assign wdata.raw = PWDATA;

    assign status_clr = rd_acc & (offset == gpio_pkg::ADDR_INTSTATUS);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            cfg <= '0;
        end
        else if (wr_acc)
        begin
            case (offset)
                gpio_pkg::ADDR_PADDIR:
                    cfg.dir <= wdata.raw;
                gpio_pkg::ADDR_GPIOEN:
                    cfg.en <= wdata.raw;
                gpio_pkg::ADDR_PADOUT:
                    cfg.out <= wdata.raw;
                gpio_pkg::ADDR_PADOUTSET:
                    cfg.out <= cfg.out | wdata.raw;   // Atomic set
                gpio_pkg::ADDR_PADOUTCLR:
                    cfg.out <= cfg.out & ~wdata.raw;  // Atomic clear
                gpio_pkg::ADDR_INTEN:
                    cfg.inten <= wdata.raw;
                gpio_pkg::ADDR_INTTYPE_LO:
                begin
                    for (int k = 0; k < HALF; k++)
                    begin
                        cfg.inttype[k] <= wdata.inttype[k];
                    end
                end
                gpio_pkg::ADDR_INTTYPE_HI:
                begin
                    for (int k = 0; k < HALF; k++)
                    begin
                        cfg.inttype[k+HALF] <= wdata.inttype[k];
                    end
                end
                default:
                begin
                    cfg <= cfg;  // Read-only or unmapped
                end
            endcase
        end
    end

    // Read mux, zero outside a read access
    always_comb
    begin
        rdata.raw = '0;
        if (rd_acc)
        begin
            case (offset)
                gpio_pkg::ADDR_PADDIR:
                    rdata.raw = cfg.dir;
                gpio_pkg::ADDR_GPIOEN:
                    rdata.raw = cfg.en;
                gpio_pkg::ADDR_PADIN:
                    rdata.raw = pad_in;
                gpio_pkg::ADDR_PADOUT:
                    rdata.raw = cfg.out;
                gpio_pkg::ADDR_INTEN:
                    rdata.raw = cfg.inten;
                gpio_pkg::ADDR_INTTYPE_LO:
                begin
                    for (int k = 0; k < HALF; k++)
                    begin
                        rdata.inttype[k] = cfg.inttype[k];
                    end
                end
                gpio_pkg::ADDR_INTTYPE_HI:
                begin
                    for (int k = 0; k < HALF; k++)
                    begin
                        rdata.inttype[k] = cfg.inttype[k+HALF];
                    end
                end
                gpio_pkg::ADDR_INTSTATUS:
                    rdata.raw = status;
                default:
                    rdata.raw = '0;  // SET, CLR and unmapped
            endcase
        end
    end

    assign PRDATA = rdata.raw;

endmodule

//--- src/gpio_edge_irq.sv
////////////////////////////////////////////////////////////
// Interrupt type match, interrupt line and status register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_edge_irq
(
    input  logic                HCLK,
    input  logic                HRESETn,

    input  gpio_pkg::gpio_cfg_t cfg,
    input  gpio_pkg::pad_edge_t edges,
    input  logic                status_clr,

    output gpio_pkg::pad_vec_t  status,
    output logic                interrupt
);

    gpio_pkg::pad_vec_t type_hit;
    gpio_pkg::pad_vec_t qual;

    always_comb
    begin
        for (int k = 0; k < gpio_pkg::PAD_NUM; k++)
        begin
            case (cfg.inttype[k])
                gpio_pkg::INT_FALL:
                    type_hit[k] = edges.fall[k];
                gpio_pkg::INT_RISE:
                    type_hit[k] = edges.rise[k];
                gpio_pkg::INT_BOTH:
                    type_hit[k] = edges.rise[k] | edges.fall[k];
                default:
                    type_hit[k] = 1'b0;  // INT_NONE
            endcase
        end
    end

    // Pad must be both interrupt enabled and sync enabled
    assign qual = type_hit & cfg.inten & cfg.en;

    assign interrupt = |qual;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status <= '0;
        end
        else if (interrupt)
        begin
            status <= status | qual;  // New edges win over a clear
        end
        else if (status_clr)
        begin
            status <= '0;
        end
    end

endmodule

//--- src/gpio_input_sync.sv
////////////////////////////////////////////////////////////
// Per-pad enabled input synchronizer with edge detect
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module gpio_input_sync
(
    input  logic                HCLK,
    input  logic                HRESETn,

    input  gpio_pkg::pad_vec_t  gpio_in,
    input  gpio_pkg::gpio_cfg_t cfg,

    output gpio_pkg::pad_vec_t  sync_out,
    output gpio_pkg::pad_vec_t  pad_in,
    output gpio_pkg::pad_edge_t edges
);

    gpio_pkg::pad_vec_t stage1;
    gpio_pkg::pad_vec_t stage2;
    gpio_pkg::pad_vec_t stage3;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            stage1 <= '0;
            stage2 <= '0;
            stage3 <= '0;
        end
        else
        begin
            for (int k = 0; k < gpio_pkg::PAD_NUM; k++)
            begin
                if (cfg.en[k])  // Disabled pads hold all stages
                begin
                    stage1[k] <= gpio_in[k];
                    stage2[k] <= stage1[k];
                    stage3[k] <= stage2[k];
                end
            end
        end
    end

    assign sync_out = stage2;
    assign pad_in   = stage3;

    assign edges.rise = stage2 & ~stage3;
    assign edges.fall = ~stage2 & stage3;

endmodule

//--- src/gpio_pkg.sv
////////////////////////////////////////////////////////////
// GPIO package with the register map, widths and shared
// types for the single-bank APB GPIO block
////////////////////////////////////////////////////////////

package gpio_pkg;

    localparam int PAD_NUM = 32;
    localparam int ADDR_W  = 12;
    localparam int DATA_W  = 32;

    // Word offsets, taken from PADDR[6:2]
    localparam logic [4:0] ADDR_PADDIR     = 5'd0;
    localparam logic [4:0] ADDR_GPIOEN     = 5'd1;
    localparam logic [4:0] ADDR_PADIN      = 5'd2;
    localparam logic [4:0] ADDR_PADOUT     = 5'd3;
    localparam logic [4:0] ADDR_PADOUTSET  = 5'd4;
    localparam logic [4:0] ADDR_PADOUTCLR  = 5'd5;
    localparam logic [4:0] ADDR_INTEN      = 5'd6;
    localparam logic [4:0] ADDR_INTTYPE_LO = 5'd7;  // Pads 0..15
    localparam logic [4:0] ADDR_INTTYPE_HI = 5'd8;  // Pads 16..31
    localparam logic [4:0] ADDR_INTSTATUS  = 5'd9;

    typedef logic [PAD_NUM-1:0] pad_vec_t;

    typedef enum logic [1:0]
    {
        INT_FALL = 2'b00,
        INT_RISE = 2'b01,
        INT_BOTH = 2'b10,
        INT_NONE = 2'b11
    } inttype_e;

    // One APB word, either raw or as half a bank of interrupt types
    typedef union packed
    {
        logic [DATA_W-1:0] raw;
        inttype_e [PAD_NUM/2-1:0] inttype;  // Pad k at bits 2k+1:2k
    } apb_word_u;

    typedef struct packed
    {
        pad_vec_t dir;
        pad_vec_t out;
        pad_vec_t inten;
        pad_vec_t en;
        inttype_e [PAD_NUM-1:0] inttype;
    } gpio_cfg_t;

    typedef struct packed
    {
        pad_vec_t rise;
        pad_vec_t fall;
    } pad_edge_t;

endpackage
